//--- logic/sb_tx_pkg.sv
package sb_tx_pkg;

    typedef logic [9:0]  symbol_t;    // Start bit, payload, stop bit
    typedef logic [7:0]  byte_t;      // Symbol payload
    typedef logic [23:0] read_data_t; // Register read data, three bytes
    typedef logic [3:0]  sym_count_t; // Bit-time within a symbol

    // Request codes as presented on trans_sel
    typedef enum logic [2:0] {
        req_none       = 3'd0,
        req_read_cmd   = 3'd2,
        req_read_rsp   = 3'd3,
        req_lane_state = 3'd4
    } req_t;

    // Reported on trans_state
    typedef enum logic [1:0] {
        link_disconnected = 2'd0,
        link_idle         = 2'd1,
        link_start        = 2'd2
    } link_state_t;

    typedef enum logic [4:0] {
        st_disconnect,
        st_idle,
        st_dle1,
        st_lse,
        st_clse,
        st_stx_cmd,
        st_cmd_addr,
        st_cmd_len,
        st_stx_rsp,
        st_rsp_addr,
        st_rsp_len,
        st_rsp_data,
        st_crc1,
        st_crc2,
        st_dle2,
        st_etx
    } frame_state_t;

    // One registered line word, unpacked at the top level
    typedef struct packed {
        symbol_t symbol;
        logic    crc_en;   // Outer CRC accumulates this symbol
        logic    sbtx_sel; // Outer CRC unit drives the line
    } sb_line_t;

    localparam int      SYMBOL_CYCLES  = 10;     // sb_clk cycles per symbol
    localparam byte_t   DLE_CODE       = 8'hFE;
    localparam byte_t   STX_CMD_CODE   = 8'h05;
    localparam byte_t   STX_RSP_CODE   = 8'h04;
    localparam byte_t   LSE_CODE       = 8'h80;
    localparam byte_t   CLSE_CODE      = ~LSE_CODE;
    localparam byte_t   ETX_CODE       = 8'h40;
    localparam byte_t   READ_ADDR      = 8'd78;  // Register read address
    localparam byte_t   READ_LEN       = 8'd3;   // Bytes requested
    localparam int      RSP_DATA_BYTES = 3;      // Data bytes in the response
    localparam symbol_t IDLE_SYMBOL    = '1;     // Line held high when idle
    localparam int      SENT_DELAY     = 3;      // Stages ahead of trans_sent

endpackage

//--- logic/sb_symbol_timer.sv
`timescale 1ns/10ps

module sb_symbol_timer (
    input  logic sb_clk,
    input  logic rst,
    input  logic active,     // Frame in progress
    output logic symbol_end  // Last bit-time of the current symbol
);
    import sb_tx_pkg::*;

    localparam sym_count_t LAST_COUNT = sym_count_t'(SYMBOL_CYCLES - 1);

    sym_count_t count; // Bit-time within the symbol

    always_ff @(posedge sb_clk or negedge rst) begin
        if (!rst) begin
            count <= '0;
        end else if (!active) begin
            count <= '0; // Parked between frames
        end else if (count == LAST_COUNT) begin
            count <= '0; // Next symbol starts
        end else begin
            count <= count + sym_count_t'(1);
        end
    end

    // Sequencer loads the next symbol on the edge that ends this cycle
    assign symbol_end = active && (count == LAST_COUNT);

endmodule

//--- logic/sb_request_tracker.sv
`timescale 1ns/10ps

module sb_request_tracker (
    input  logic              sb_clk,
    input  logic              rst,
    input  sb_tx_pkg::req_t   trans_sel,  // Request from the link layer
    input  logic              frame_done, // Final symbol of a frame ends
    output sb_tx_pkg::req_t   req,        // Request being served
    output logic              trans_sent  // Delayed completion pulse
);
    import sb_tx_pkg::*;

    logic                  done_kept; // Completion not overrun by a new request
    logic [SENT_DELAY-1:0] sent_pipe; // Completion delay line

    // A request arriving with the completion wins over it
    assign done_kept = frame_done && (trans_sel == req_none);

    always_ff @(posedge sb_clk or negedge rst) begin
        if (!rst) begin
            req <= req_none;
        end else if (trans_sel != req_none) begin
            req <= trans_sel; // Latest nonzero request
        end else if (frame_done) begin
            req <= req_none; // Frame finished, back to idle
        end
    end

    // Delay so the far end sees the pulse after the last symbol settles
    always_ff @(posedge sb_clk or negedge rst) begin
        if (!rst) begin
            sent_pipe  <= '0;
            trans_sent <= 1'b0;
        end else begin
            sent_pipe  <= {sent_pipe[SENT_DELAY-2:0], done_kept};
            trans_sent <= sent_pipe[SENT_DELAY-1]; // Single-cycle pulse
        end
    end

endmodule

//--- logic/sb_frame_sequencer.sv
`timescale 1ns/10ps

module sb_frame_sequencer (
    input  logic                    sb_clk,
    input  logic                    rst,
    input  sb_tx_pkg::req_t         req,                // Active request
    input  logic                    symbol_end,         // Current symbol on its last cycle
    input  sb_tx_pkg::read_data_t   sb_read,            // Data for the read response
    input  logic                    disconnect_sbtx,    // Hold the link disconnected
    input  logic                    tdisconnect_tx_min, // Minimum disconnect time met
    output logic                    active,             // Symbol timer runs
    output logic                    frame_done,         // CLSE or ETX finishing
    output sb_tx_pkg::sb_line_t     line,               // Registered symbol and flags
    output sb_tx_pkg::link_state_t  link_state
);
    import sb_tx_pkg::*;

    localparam logic [1:0] LAST_BYTE = 2'(RSP_DATA_BYTES - 1);

    frame_state_t state;
    frame_state_t state_nxt;
    logic         advance;    // Symbol done and request still matches
    logic         load_line;  // Register a new line word this cycle
    logic [1:0]   byte_cnt;   // Response byte now on the line
    logic [1:0]   byte_sel;   // Response byte loaded on the next advance
    byte_t        rsp_byte;   // Selected sb_read byte

    // Start bit high, stop bit low
    function automatic symbol_t frame_sym(byte_t payload);
        return {1'b1, payload, 1'b0};
    endfunction

    // Symbol and CRC flags that go with a state
    function automatic sb_line_t line_for(frame_state_t st, byte_t data);
        sb_line_t l;
        l = '{symbol: '0, crc_en: 1'b0, sbtx_sel: 1'b0};
        case (st)
            st_idle:                 l.symbol = IDLE_SYMBOL;
            st_dle1, st_dle2:        l.symbol = frame_sym(DLE_CODE); // Not CRC covered
            st_lse: begin
                l.symbol = frame_sym(LSE_CODE);
                l.crc_en = 1'b1;
            end
            st_clse: begin
                l.symbol = frame_sym(CLSE_CODE);
                l.crc_en = 1'b1;
            end
            st_stx_cmd: begin
                l.symbol = frame_sym(STX_CMD_CODE);
                l.crc_en = 1'b1;
            end
            st_stx_rsp: begin
                l.symbol = frame_sym(STX_RSP_CODE);
                l.crc_en = 1'b1;
            end
            st_cmd_addr, st_rsp_addr: begin
                l.symbol = frame_sym(READ_ADDR);
                l.crc_en = 1'b1;
            end
            st_cmd_len, st_rsp_len: begin
                l.symbol = frame_sym(READ_LEN);
                l.crc_en = 1'b1;
            end
            st_rsp_data: begin
                l.symbol = frame_sym(data); // Byte captured at load
                l.crc_en = 1'b1;
            end
            st_crc1, st_crc2: begin
                l.crc_en   = 1'b1; // Zero slot, outer unit drives the CRC
                l.sbtx_sel = 1'b1;
            end
            st_etx:                  l.symbol = frame_sym(ETX_CODE);
            default:                 l.symbol = '0; // Disconnected line
        endcase
        return l;
    endfunction

    // Frame continues only while the request matches its type
    function automatic logic req_fits(frame_state_t st, req_t r);
        logic fits;
        case (st)
            st_dle1:
                fits = r inside {req_read_cmd, req_read_rsp, req_lane_state};
            st_lse, st_clse:
                fits = (r == req_lane_state);
            st_stx_cmd, st_cmd_addr, st_cmd_len:
                fits = (r == req_read_cmd);
            st_stx_rsp, st_rsp_addr, st_rsp_len, st_rsp_data:
                fits = (r == req_read_rsp);
            st_crc1, st_crc2, st_dle2, st_etx:
                fits = r inside {req_read_cmd, req_read_rsp}; // Shared frame tail
            default:
                fits = 1'b0;
        endcase
        return fits;
    endfunction

    assign active = (state != st_disconnect) && (state != st_idle);

    // Length symbol leads to byte 0, each data symbol to the next byte
    assign byte_sel = (state == st_rsp_len) ? 2'd0 : byte_cnt + 2'd1;

    always_comb begin
        case (byte_sel)
            2'd0:    rsp_byte = sb_read[7:0]; // Low byte first
            2'd1:    rsp_byte = sb_read[15:8];
            default: rsp_byte = sb_read[23:16];
        endcase
    end

    always_comb begin
        state_nxt = state;
        advance   = 1'b0;
        case (state)
            st_disconnect: begin
                if (!disconnect_sbtx && tdisconnect_tx_min) begin
                    state_nxt = st_idle; // Release to idle
                end
            end
            st_idle: begin
                if (req inside {req_read_cmd, req_read_rsp, req_lane_state}) begin
                    state_nxt = st_dle1; // Every frame opens with DLE
                end
            end
            default: begin
                if (symbol_end && req_fits(state, req)) begin
                    advance = 1'b1;
                    case (state)
                        st_dle1: begin
                            if (req == req_lane_state) begin
                                state_nxt = st_lse;
                            end else if (req == req_read_cmd) begin
                                state_nxt = st_stx_cmd;
                            end else begin
                                state_nxt = st_stx_rsp;
                            end
                        end
                        st_lse:      state_nxt = st_clse;
                        st_clse:     state_nxt = st_idle;
                        st_stx_cmd:  state_nxt = st_cmd_addr;
                        st_cmd_addr: state_nxt = st_cmd_len;
                        st_cmd_len:  state_nxt = st_crc1; // No data in the command
                        st_stx_rsp:  state_nxt = st_rsp_addr;
                        st_rsp_addr: state_nxt = st_rsp_len;
                        st_rsp_len:  state_nxt = st_rsp_data;
                        st_rsp_data: begin
                            if (byte_cnt == LAST_BYTE) begin
                                state_nxt = st_crc1;
                            end
                        end
                        st_crc1:     state_nxt = st_crc2;
                        st_crc2:     state_nxt = st_dle2;
                        st_dle2:     state_nxt = st_etx;
                        default:     state_nxt = st_idle; // ETX ends the frame
                    endcase
                end
            end
        endcase
    end

    // Idle and disconnect refresh every cycle, frames only on an advance
    assign load_line  = (state == st_disconnect) || (state == st_idle) || advance;
    assign frame_done = advance && ((state == st_clse) || (state == st_etx));

    always_ff @(posedge sb_clk or negedge rst) begin
        if (!rst) begin
            state      <= st_disconnect;
            line       <= '0;
            link_state <= link_disconnected;
        end else begin
            state <= state_nxt;
            if (load_line) begin
                line <= line_for(state_nxt, rsp_byte);
            end
            case (state_nxt)
                st_disconnect: link_state <= link_disconnected;
                st_idle:       link_state <= link_idle;
                default:       link_state <= link_start; // Frame on the line
            endcase
        end
    end

    always_ff @(posedge sb_clk or negedge rst) begin
        if (!rst) begin
            byte_cnt <= '0;
        end else if (state == st_idle) begin
            byte_cnt <= '0;
        end else if (advance && (state_nxt == st_rsp_data)) begin
            byte_cnt <= byte_sel; // Tracks the byte just loaded
        end
    end

endmodule

//--- logic/sb_transaction_gen.sv
`timescale 1ns/10ps

module sb_transaction_gen (
    input  logic                    sb_clk,
    input  logic                    rst,
    input  sb_tx_pkg::read_data_t   sb_read,            // Register read data
    input  sb_tx_pkg::req_t         trans_sel,          // Transaction request
    input  logic                    disconnect_sbtx,
    input  logic                    tdisconnect_tx_min,
    output sb_tx_pkg::symbol_t      trans,              // Line symbol
    output sb_tx_pkg::link_state_t  trans_state,
    output logic                    crc_en,             // CRC accumulate enable
    output logic                    sbtx_sel,           // CRC unit owns the line
    output logic                    trans_sent,         // Frame completion pulse
    output logic                    disconnected_s
);
    import sb_tx_pkg::*;

    req_t     req;         // Request under service
    logic     frame_done;  // Sequencer finished a frame
    logic     active;      // Timer enable
    logic     symbol_end;  // Symbol boundary strobe
    sb_line_t line;        // Registered symbol and flags

    sb_symbol_timer u_timer (
        .sb_clk     (sb_clk),
        .rst        (rst),
        .active     (active),
        .symbol_end (symbol_end)
    );

    sb_request_tracker u_tracker (
        .sb_clk     (sb_clk),
        .rst        (rst),
        .trans_sel  (trans_sel),
        .frame_done (frame_done),
        .req        (req),
        .trans_sent (trans_sent)
    );

    sb_frame_sequencer u_sequencer (
        .sb_clk             (sb_clk),
        .rst                (rst),
        .req                (req),
        .symbol_end         (symbol_end),
        .sb_read            (sb_read),
        .disconnect_sbtx    (disconnect_sbtx),
        .tdisconnect_tx_min (tdisconnect_tx_min),
        .active             (active),
        .frame_done         (frame_done),
        .line               (line),
        .link_state         (trans_state)
    );

    assign trans    = line.symbol;
    assign crc_en   = line.crc_en;
    assign sbtx_sel = line.sbtx_sel;

    // Only the disconnect state reports link_disconnected
    assign disconnected_s = (trans_state == link_disconnected);

endmodule

//--- verif/sb_transaction_gen_asserts.sv
`timescale 1ns/10ps

module sb_transaction_gen_asserts (
    input logic                   sb_clk,
    input logic                   rst,
    input sb_tx_pkg::read_data_t  sb_read,
    input sb_tx_pkg::req_t        trans_sel,
    input logic                   disconnect_sbtx,
    input logic                   tdisconnect_tx_min,
    input sb_tx_pkg::symbol_t     trans,
    input sb_tx_pkg::link_state_t trans_state,
    input logic                   crc_en,
    input logic                   sbtx_sel,
    input logic                   trans_sent,
    input logic                   disconnected_s
);
    import sb_tx_pkg::*;

    int         fail_count = 0; // Read by the testbench
    req_t       kind;           // Frame type under check
    read_data_t data;           // sb_read taken with the request
    logic       released;       // Link has left disconnect
    logic       pending;        // Request seen, first DLE not yet on the line
    logic       in_frame;
    int         req_age;        // Cycles since the request was sampled
    int         pos;            // Symbol index within the frame
    int         bit_cnt;        // Cycle within the symbol
    logic [2:0] sent_exp;       // Expected trans_sent delay line
    logic       start_seen;
    logic       end_seen;
    logic       checking;
    sb_line_t   exp_line;

    function automatic symbol_t to_sym(byte_t b);
        return {1'b1, b, 1'b0}; // Start bit 1, stop bit 0
    endfunction

    function automatic int frame_len(req_t k);
        if (k == req_lane_state) begin
            return 3;
        end
        return (k == req_read_rsp) ? 8 + RSP_DATA_BYTES : 8;
    endfunction

    // Expected line word for symbol idx and idle beyond the frame
    function automatic sb_line_t expect_at(req_t k, int idx, read_data_t d);
        int       tail; // First CRC slot
        sb_line_t l;
        tail = (k == req_read_rsp) ? 4 + RSP_DATA_BYTES : 4;
        l    = '{symbol: IDLE_SYMBOL, crc_en: 1'b0, sbtx_sel: 1'b0};
        if (idx == 0) begin
            l.symbol = to_sym(DLE_CODE);
        end else if (k == req_lane_state) begin
            if (idx < 3) begin
                l.symbol = to_sym((idx == 1) ? LSE_CODE : CLSE_CODE);
                l.crc_en = 1'b1;
            end
        end else if (idx < tail) begin
            l.crc_en = 1'b1; // STX up to the last data byte
            case (idx)
                1:       l.symbol = to_sym((k == req_read_cmd) ? STX_CMD_CODE : STX_RSP_CODE);
                2:       l.symbol = to_sym(READ_ADDR);
                3:       l.symbol = to_sym(READ_LEN);
                default: l.symbol = to_sym(d[8*(idx-4) +: 8]); // Low byte first
            endcase
        end else if (idx < tail + 2) begin
            l = '{symbol: '0, crc_en: 1'b1, sbtx_sel: 1'b1}; // Empty CRC slot
        end else if (idx == tail + 2) begin
            l.symbol = to_sym(DLE_CODE);
        end else if (idx == tail + 3) begin
            l.symbol = to_sym(ETX_CODE);
        end
        return l;
    endfunction

    assign start_seen = pending && (trans != IDLE_SYMBOL);
    assign end_seen   = in_frame && (pos == frame_len(kind));
    assign checking   = in_frame || start_seen;
    assign exp_line   = expect_at(kind, start_seen ? 0 : pos, data);

    always_ff @(posedge sb_clk or negedge rst) begin
        if (!rst) begin
            released <= 1'b0;
            pending  <= 1'b0;
            in_frame <= 1'b0;
            kind     <= req_none;
            data     <= '0;
            req_age  <= 0;
            pos      <= 0;
            bit_cnt  <= 0;
            sent_exp <= '0;
        end else begin
            sent_exp <= {sent_exp[1:0], end_seen};
            if (!disconnect_sbtx && tdisconnect_tx_min) begin
                released <= 1'b1;
            end
            if (released && !pending && !in_frame && (trans_sel != req_none)) begin
                pending <= 1'b1;
                kind    <= trans_sel;
                data    <= sb_read; // Held by the stimulus for the whole frame
                req_age <= 1;
            end else if (start_seen) begin
                pending  <= 1'b0;
                in_frame <= 1'b1;
                pos      <= 0;
                bit_cnt  <= 1; // First DLE cycle checked here
            end else if (pending) begin
                req_age <= req_age + 1;
            end else if (end_seen) begin
                in_frame <= 1'b0;
            end else if (in_frame) begin
                if (bit_cnt == SYMBOL_CYCLES - 1) begin
                    bit_cnt <= 0;
                    pos     <= pos + 1; // Next symbol
                end else begin
                    bit_cnt <= bit_cnt + 1;
                end
            end
        end
    end

    a_disconnected: assert property (@(posedge sb_clk) disable iff (!rst)
        !released |-> disconnected_s && (trans == '0) && (trans_state == link_disconnected))
        else begin
            fail_count++;
            $error("error at %0t disconnected_s got %b expected 1, trans got %h expected 000",
                   $time, $sampled(disconnected_s), $sampled(trans));
        end

    // Flag drops once the link has left disconnect
    a_connected: assert property (@(posedge sb_clk) disable iff (!rst)
        released |-> !disconnected_s)
        else begin
            fail_count++;
            $error("error at %0t disconnected_s got %b expected 0",
                   $time, $sampled(disconnected_s));
        end

    a_release: assert property (@(posedge sb_clk) disable iff (!rst)
        (!released && !disconnect_sbtx && tdisconnect_tx_min)
            |=> (trans == IDLE_SYMBOL) && (trans_state == link_idle))
        else begin
            fail_count++;
            $error("error at %0t trans_state got %0d expected %0d after release",
                   $time, $sampled(trans_state), link_idle);
        end

    a_idle: assert property (@(posedge sb_clk) disable iff (!rst)
        (released && !pending && !in_frame)
            |-> (trans == IDLE_SYMBOL) && !crc_en && !sbtx_sel && (trans_state == link_idle))
        else begin
            fail_count++;
            $error("error at %0t trans got %h expected %h between frames",
                   $time, $sampled(trans), IDLE_SYMBOL);
        end

    a_start_delay: assert property (@(posedge sb_clk) disable iff (!rst)
        start_seen |-> (req_age == 2))
        else begin
            fail_count++;
            $error("error at %0t first DLE delay got %0d expected 2",
                   $time, $sampled(req_age));
        end

    a_symbol: assert property (@(posedge sb_clk) disable iff (!rst)
        checking |-> (trans == exp_line.symbol))
        else begin
            fail_count++;
            $error("error at %0t trans got %h expected %h", $time, $sampled(trans),
                   $sampled(exp_line.symbol));
        end

    a_crc_en: assert property (@(posedge sb_clk) disable iff (!rst)
        checking |-> (crc_en == exp_line.crc_en))
        else begin
            fail_count++;
            $error("error at %0t crc_en got %b expected %b", $time, $sampled(crc_en),
                   $sampled(exp_line.crc_en));
        end

    a_sbtx_sel: assert property (@(posedge sb_clk) disable iff (!rst)
        checking |-> (sbtx_sel == exp_line.sbtx_sel))
        else begin
            fail_count++;
            $error("error at %0t sbtx_sel got %b expected %b", $time, $sampled(sbtx_sel),
                   $sampled(exp_line.sbtx_sel));
        end

    a_link_start: assert property (@(posedge sb_clk) disable iff (!rst)
        (checking && !end_seen) |-> (trans_state == link_start))
        else begin
            fail_count++;
            $error("error at %0t trans_state got %0d expected %0d in a frame",
                   $time, $sampled(trans_state), link_start);
        end

    // Pulse lands three samples after the idle symbol first shows
    a_trans_sent: assert property (@(posedge sb_clk) disable iff (!rst)
        trans_sent == sent_exp[2])
        else begin
            fail_count++;
            $error("error at %0t trans_sent got %b expected %b", $time, $sampled(trans_sent),
                   $sampled(sent_exp[2]));
        end

endmodule

//--- verif/tb_sb_transaction_gen.sv
`timescale 1ns/10ps

module tb_sb_transaction_gen;
    import sb_tx_pkg::*;

    // Longest frame is 11 symbols, six tests with gaps stay well under this
    localparam int TIMEOUT_CYCLES = 1500;

    logic        sb_clk;
    logic        rst;
    read_data_t  sb_read;
    req_t        trans_sel;
    logic        disconnect_sbtx;
    logic        tdisconnect_tx_min;
    symbol_t     trans;
    link_state_t trans_state;
    logic        crc_en;
    logic        sbtx_sel;
    logic        trans_sent;
    logic        disconnected_s;

    logic [31:0] rng_state;    // Xorshift state
    int          cycles;       // Watchdog count
    int          tests_run;
    int          tests_failed;
    int          seen_fails;   // Assertion failures before the current test

    bind sb_transaction_gen sb_transaction_gen_asserts u_checks (
        .sb_clk             (sb_clk),
        .rst                (rst),
        .sb_read            (sb_read),
        .trans_sel          (trans_sel),
        .disconnect_sbtx    (disconnect_sbtx),
        .tdisconnect_tx_min (tdisconnect_tx_min),
        .trans              (trans),
        .trans_state        (trans_state),
        .crc_en             (crc_en),
        .sbtx_sel           (sbtx_sel),
        .trans_sent         (trans_sent),
        .disconnected_s     (disconnected_s)
    );

    sb_transaction_gen DUT (
        .sb_clk             (sb_clk),
        .rst                (rst),
        .sb_read            (sb_read),
        .trans_sel          (trans_sel),
        .disconnect_sbtx    (disconnect_sbtx),
        .tdisconnect_tx_min (tdisconnect_tx_min),
        .trans              (trans),
        .trans_state        (trans_state),
        .crc_en             (crc_en),
        .sbtx_sel           (sbtx_sel),
        .trans_sent         (trans_sent),
        .disconnected_s     (disconnected_s)
    );

    always #2 sb_clk = ~sb_clk; // 4 ns period

    function automatic logic [31:0] next_random(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // One-cycle request, then wait for the completion pulse
    task automatic send_request(req_t kind);
        @(posedge sb_clk);
        rng_state = next_random(rng_state);
        trans_sel <= kind;
        sb_read   <= rng_state[23:0]; // Stable until the next request
        @(posedge sb_clk);
        trans_sel <= req_none;
        @(negedge sb_clk);
        while (!trans_sent) begin
            @(negedge sb_clk);
        end
        repeat (3) @(posedge sb_clk); // Idle gap
    endtask

    task automatic report_test(string name);
        int now_fails;
        now_fails = DUT.u_checks.fail_count;
        tests_run++;
        if (now_fails != seen_fails) begin
            tests_failed++;
        end
        $display("test %-16s %s, %0d assertion failures", name,
                 (now_fails == seen_fails) ? "ok" : "failed", now_fails - seen_fails);
        seen_fails = now_fails;
    endtask

    initial begin : watchdog
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge sb_clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the DUT never finished its frames", cycles);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        sb_clk             = 1'b0;
        rst                = 1'b0;
        sb_read            = '0;
        trans_sel          = req_none;
        disconnect_sbtx    = 1'b1;
        tdisconnect_tx_min = 1'b0;
        rng_state          = 32'd29; // Seed
        tests_run          = 0;
        tests_failed       = 0;
        seen_fails         = 0;

        repeat (5) @(posedge sb_clk);
        rst <= 1'b1;

        repeat (4) @(posedge sb_clk);
        tdisconnect_tx_min <= 1'b1; // Disconnect request still holds the link
        repeat (4) @(posedge sb_clk);
        disconnect_sbtx <= 1'b0;
        @(negedge sb_clk);
        while (trans_state != link_idle) begin
            @(negedge sb_clk);
        end
        repeat (3) @(posedge sb_clk);
        report_test("link_control");

        send_request(req_lane_state);
        report_test("lane_state");
        send_request(req_read_cmd);
        report_test("read_command");
        send_request(req_read_rsp);
        report_test("read_response");
        send_request(req_read_rsp);
        report_test("read_response_2");
        send_request(req_lane_state);
        report_test("lane_state_2");

        $display("tests run %0d, tests failed %0d, assertion failures %0d",
                 tests_run, tests_failed, DUT.u_checks.fail_count);
        if ((tests_failed == 0) && (DUT.u_checks.fail_count == 0)) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
logic/sb_tx_pkg.sv
logic/sb_symbol_timer.sv
logic/sb_request_tracker.sv
logic/sb_frame_sequencer.sv
logic/sb_transaction_gen.sv
verif/sb_transaction_gen_asserts.sv
verif/tb_sb_transaction_gen.sv

//--- Makefile
TOP := tb_sb_transaction_gen

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Simulation FAILED" sim.log; then echo "Run failed, see sim.log"; exit 1; fi
	@grep -q "Simulation PASSED" sim.log || (echo "Run ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
